// File: serial_bus_pkg.sv
`default_nettype none

package serial_bus_pkg;

    localparam logic [2:0] START_CODE = 3'b111;  // opens every frame

    typedef enum logic {
        DIR_READ  = 1'b0,
        DIR_WRITE = 1'b1
    } xfer_dir_e;

    typedef enum logic [2:0] {
        M_IDLE, M_FRAME, M_WAIT, M_WDATA, M_RDATA, M_DONE
    } master_state_e;

    typedef enum logic [2:0] {
        S_IDLE, S_FRAME, S_DECODE, S_FETCH, S_READ, S_WRITE, S_STORE
    } slave_state_e;

    // start code, id, dir, burst, address
    function automatic int frame_bits(input int id_w, input int addr_w);
        return 3 + id_w + 2 + addr_w;
    endfunction

endpackage

`default_nettype wire

// File: serial_link_if.sv
`timescale 1ns/10ps
`default_nettype none

interface serial_link_if;
    logic control;  // frame bits, low between frames
    logic wd;
    logic valid;
    logic last;     // final word of the transfer
    logic rd;
    logic ready;

    modport master (
        output control, wd, valid, last,
        input  rd, ready
    );

    modport slave (
        input  control, wd, valid, last,
        output rd, ready
    );
endinterface

`default_nettype wire

// File: serial_master.sv
`timescale 1ns/10ps
`default_nettype none

module serial_master #(
    parameter int SLAVES     = 3,
    parameter int ADDR_DEPTH = 256,
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          cmd_start,
    input  logic                          cmd_write,
    input  logic [$clog2(SLAVES)-1:0]     cmd_slave,
    input  logic [$clog2(ADDR_DEPTH)-1:0] cmd_addr,
    input  logic [4:0]                    cmd_len,
    input  logic [DATA_WIDTH-1:0]         wr_data,
    output logic                          wr_req,
    output logic [DATA_WIDTH-1:0]         rd_data,
    output logic                          rd_valid,
    output logic                          busy,
    output logic                          done,
    serial_link_if.master                 link
);
    import serial_bus_pkg::*;

    localparam int ID_W    = $clog2(SLAVES);
    localparam int ADDR_W  = $clog2(ADDR_DEPTH);
    localparam int FRAME_W = frame_bits(ID_W, ADDR_W);
    localparam int FCNT_W  = $clog2(FRAME_W);
    localparam int BCNT_W  = $clog2(DATA_WIDTH);

    master_state_e         state;
    xfer_dir_e             dir;
    logic [FRAME_W-1:0]    frame_sr;
    logic [FCNT_W-1:0]     fcnt;
    logic [DATA_WIDTH-1:0] dsr;       // write or read word shifter
    logic [BCNT_W-1:0]     bcnt;
    logic [4:0]            wcnt;      // words done so far
    logic [4:0]            len;
    logic                  wsh;       // write word loaded, shifting
    logic                  bit_end;
    logic                  last_word;

    assign bit_end   = (bcnt == BCNT_W'(DATA_WIDTH - 1));
    assign last_word = (wcnt == len - 5'd1);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= M_IDLE;
            dir      <= DIR_READ;
            fcnt     <= '0;
            bcnt     <= '0;
            wcnt     <= '0;
            len      <= '0;
            wsh      <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            wr_req   <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            done     <= 1'b0;
            wr_req   <= 1'b0;
            rd_valid <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (cmd_start) begin
                        dir   <= xfer_dir_e'(cmd_write);
                        len   <= cmd_len;
                        fcnt  <= '0;
                        bcnt  <= '0;
                        wcnt  <= '0;
                        busy  <= 1'b1;
                        state <= M_FRAME;
                    end
                end
                M_FRAME: begin
                    fcnt <= fcnt + FCNT_W'(1);
                    if (fcnt == FCNT_W'(FRAME_W - 1))
                        state <= (dir == DIR_WRITE) ? M_WAIT : M_RDATA;
                end
                M_WAIT: begin
                    if (link.ready) begin  // slave has decoded the frame
                        wr_req <= 1'b1;
                        wsh    <= 1'b0;
                        state  <= M_WDATA;
                    end
                end
                M_WDATA: begin
                    if (wsh) begin
                        bcnt <= bcnt + BCNT_W'(1);
                        if (bit_end) begin
                            bcnt <= '0;
                            wcnt <= wcnt + 5'd1;
                            if (last_word) begin
                                state <= M_DONE;
                            end else begin
                                wr_req <= 1'b1;  // fetch the next word
                                wsh    <= 1'b0;
                            end
                        end
                    end else if (!wr_req) begin
                        wsh <= 1'b1;  // wr_data sampled on this edge
                    end
                end
                M_RDATA: begin
                    if (link.ready) begin
                        bcnt <= bcnt + BCNT_W'(1);
                        if (bit_end) begin
                            bcnt     <= '0;
                            rd_valid <= 1'b1;
                            wcnt     <= wcnt + 5'd1;
                            if (last_word)
                                state <= M_DONE;
                        end
                    end
                end
                M_DONE: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= M_IDLE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_IDLE && cmd_start)
            frame_sr <= {START_CODE, cmd_slave, cmd_write, (cmd_len > 5'd1), cmd_addr};
        else if (state == M_FRAME)
            frame_sr <= frame_sr << 1;

        if (state == M_WDATA && !wsh && !wr_req)
            dsr <= wr_data;
        else if (state == M_WDATA && wsh)
            dsr <= dsr << 1;
        else if (state == M_RDATA && link.ready)
            dsr <= {dsr[DATA_WIDTH-2:0], link.rd};

        if (state == M_RDATA && link.ready && bit_end)
            rd_data <= {dsr[DATA_WIDTH-2:0], link.rd};  // msb first
    end

    assign link.control = (state == M_FRAME) & frame_sr[FRAME_W-1];
    assign link.valid   = (state == M_WDATA) & wsh;
    assign link.wd      = link.valid & dsr[DATA_WIDTH-1];
    assign link.last    = (link.valid || state == M_RDATA) && last_word;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!resetn)
        cmd_start |-> !busy)
        else $error("cmd_start while busy");

endmodule

`default_nettype wire

// File: serial_fabric.sv
`timescale 1ns/10ps
`default_nettype none

module serial_fabric #(
    parameter int SLAVES = 3
) (
    serial_link_if.slave  bus,
    serial_link_if.master port [SLAVES]
);

    logic [SLAVES-1:0] rd_vec;
    logic [SLAVES-1:0] ready_vec;

    // every slave sees the same frame and write stream
    for (genvar i = 0; i < SLAVES; i++) begin : g_port
        assign port[i].control = bus.control;
        assign port[i].wd      = bus.wd;
        assign port[i].valid   = bus.valid;
        assign port[i].last    = bus.last;
        assign rd_vec[i]       = port[i].rd;
        assign ready_vec[i]    = port[i].ready;
    end

    // idle slaves hold rd and ready low
    assign bus.rd    = |rd_vec;
    assign bus.ready = |ready_vec;

    always_comb begin
        a_one_ready: assert ($onehot0(ready_vec))
            else $error("more than one slave drives ready");
    end

endmodule

`default_nettype wire

// File: serial_slave.sv
`timescale 1ns/10ps
`default_nettype none

module serial_slave #(
    parameter int ADDR_DEPTH = 256,
    parameter int DATA_WIDTH = 32,
    parameter int SLAVES     = 3
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic [$clog2(SLAVES)-1:0] slave_id,
    serial_link_if.slave              link
);
    import serial_bus_pkg::*;

    localparam int ID_W    = $clog2(SLAVES);
    localparam int ADDR_W  = $clog2(ADDR_DEPTH);
    localparam int FRAME_W = frame_bits(ID_W, ADDR_W);
    localparam int FCNT_W  = $clog2(FRAME_W);
    localparam int BCNT_W  = $clog2(DATA_WIDTH);

    slave_state_e          state;
    logic [FRAME_W-1:0]    frame_sr;
    logic [FCNT_W-1:0]     fcnt;
    logic [DATA_WIDTH-1:0] dsr;
    logic [BCNT_W-1:0]     bcnt;
    logic [ADDR_W-1:0]     addr;
    logic                  burst;
    logic                  last_q;   // last seen on the final bit of a write word
    logic                  ready_q;
    logic                  bit_end;
    logic                  hit;

    logic [DATA_WIDTH-1:0] mem [ADDR_DEPTH];

    assign bit_end = (bcnt == BCNT_W'(DATA_WIDTH - 1));

    // start code and id both have to match
    assign hit = (frame_sr[FRAME_W-1 -: 3] == START_CODE) &&
                 (frame_sr[FRAME_W-4 -: ID_W] == slave_id);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= S_IDLE;
            fcnt    <= '0;
            bcnt    <= '0;
            addr    <= '0;
            burst   <= 1'b0;
            last_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (link.control) begin  // first start bit
                        fcnt  <= FCNT_W'(1);
                        state <= S_FRAME;
                    end
                end
                S_FRAME: begin
                    fcnt <= fcnt + FCNT_W'(1);
                    if (fcnt == FCNT_W'(FRAME_W - 1))
                        state <= S_DECODE;
                end
                S_DECODE: begin
                    if (hit) begin
                        addr  <= frame_sr[ADDR_W-1:0];
                        burst <= frame_sr[ADDR_W];
                        bcnt  <= '0;
                        if (xfer_dir_e'(frame_sr[ADDR_W+1]) == DIR_WRITE) begin
                            ready_q <= 1'b1;
                            state   <= S_WRITE;
                        end else begin
                            state <= S_FETCH;
                        end
                    end else begin
                        state <= S_IDLE;  // frame for another slave
                    end
                end
                S_FETCH: begin
                    ready_q <= 1'b1;
                    state   <= S_READ;
                end
                S_READ: begin
                    bcnt <= bcnt + BCNT_W'(1);
                    if (bit_end) begin
                        bcnt    <= '0;
                        ready_q <= 1'b0;  // low for one fetch cycle at least
                        if (link.last || !burst) begin
                            state <= S_IDLE;
                        end else begin
                            addr  <= addr + ADDR_W'(1);  // wraps at ADDR_DEPTH
                            state <= S_FETCH;
                        end
                    end
                end
                S_WRITE: begin
                    if (link.valid) begin
                        bcnt <= bcnt + BCNT_W'(1);
                        if (bit_end) begin
                            bcnt   <= '0;
                            last_q <= link.last;
                            state  <= S_STORE;
                        end
                    end
                end
                S_STORE: begin
                    addr <= addr + ADDR_W'(1);
                    if (last_q || !burst) begin
                        ready_q <= 1'b0;
                        state   <= S_IDLE;
                    end else begin
                        state <= S_WRITE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // frame, word shifter and memory array
    always_ff @(posedge clk) begin
        if ((state == S_IDLE && link.control) || state == S_FRAME)
            frame_sr <= {frame_sr[FRAME_W-2:0], link.control};

        if (state == S_FETCH)
            dsr <= mem[addr];
        else if (state == S_READ)
            dsr <= dsr << 1;
        else if (state == S_WRITE && link.valid)
            dsr <= {dsr[DATA_WIDTH-2:0], link.wd};

        if (state == S_STORE)
            mem[addr] <= dsr;
    end

    assign link.rd    = (state == S_READ) & dsr[DATA_WIDTH-1];  // msb first
    assign link.ready = ready_q;

    a_no_valid_in_read: assert property (@(posedge clk) disable iff (!resetn)
        state == S_READ |-> !link.valid)
        else $error("valid high while slave %0d sends read data", slave_id);

endmodule

`default_nettype wire

// File: serial_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module serial_bus_top #(
    parameter int SLAVES     = 3,
    parameter int ADDR_DEPTH = 256,
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          cmd_start,
    input  logic                          cmd_write,
    input  logic [$clog2(SLAVES)-1:0]     cmd_slave,
    input  logic [$clog2(ADDR_DEPTH)-1:0] cmd_addr,
    input  logic [4:0]                    cmd_len,
    input  logic [DATA_WIDTH-1:0]         wr_data,
    output logic                          wr_req,
    output logic [DATA_WIDTH-1:0]         rd_data,
    output logic                          rd_valid,
    output logic                          busy,
    output logic                          done
);

    localparam int ID_W = $clog2(SLAVES);

    serial_link_if m_link ();
    serial_link_if s_link [SLAVES] ();

    serial_master #(
        .SLAVES     (SLAVES),
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_master (
        .clk       (clk),
        .resetn    (resetn),
        .cmd_start (cmd_start),
        .cmd_write (cmd_write),
        .cmd_slave (cmd_slave),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .wr_data   (wr_data),
        .wr_req    (wr_req),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .busy      (busy),
        .done      (done),
        .link      (m_link)
    );

    serial_fabric #(.SLAVES(SLAVES)) u_fabric (
        .bus  (m_link),
        .port (s_link)
    );

    for (genvar i = 0; i < SLAVES; i++) begin : g_slave
        serial_slave #(
            .ADDR_DEPTH (ADDR_DEPTH),
            .DATA_WIDTH (DATA_WIDTH),
            .SLAVES     (SLAVES)
        ) u_slave (
            .clk      (clk),
            .resetn   (resetn),
            .slave_id (ID_W'(i)),  // id is the slot number
            .link     (s_link[i])
        );
    end

endmodule

`default_nettype wire

// File: tb_serial_bus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_serial_bus;

    localparam int SLAVES       = 3;
    localparam int ADDR_DEPTH   = 256;
    localparam int DATA_WIDTH   = 32;
    localparam int ID_W         = $clog2(SLAVES);
    localparam int ADDR_W       = $clog2(ADDR_DEPTH);
    localparam int FRAME_W      = 3 + ID_W + 2 + ADDR_W;  // start, id, dir, burst, address
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_CMDS  = 150;

    // fill, single pairs, wrap pair, isolation, random mix
    localparam int N_CMDS      = SLAVES * ADDR_DEPTH / 16 + 2 * SLAVES + 2 + 1 + SLAVES
                                 + RANDOM_CMDS;
    localparam int CYCLE_LIMIT = N_CMDS * (FRAME_W + 16 * (DATA_WIDTH + 2) + 10)
                                 + RESET_CYCLES + 10;

    logic                  clk;
    logic                  resetn;
    logic                  cmd_start;
    logic                  cmd_write;
    logic [ID_W-1:0]       cmd_slave;
    logic [ADDR_W-1:0]     cmd_addr;
    logic [4:0]            cmd_len;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  wr_req;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_valid;
    logic                  busy;
    logic                  done;

    logic [DATA_WIDTH-1:0] model [SLAVES][ADDR_DEPTH];  // reference memories
    logic [DATA_WIDTH-1:0] wq [$];                      // words for the next write
    logic [31:0]           lcg_state;

    int checks       = 0;
    int errors       = 0;
    int tests        = 0;
    int failed_tests = 0;
    int cycles       = 0;

    serial_bus_top #(
        .SLAVES     (SLAVES),
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) serial_bus_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .cmd_start (cmd_start),
        .cmd_write (cmd_write),
        .cmd_slave (cmd_slave),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .wr_data   (wr_data),
        .wr_req    (wr_req),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .busy      (busy),
        .done      (done)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int n);
        return int'((next_random() >> 8) % n);  // low lcg bits are weak
    endfunction

    // depends on every address bit and on the slave
    function automatic logic [DATA_WIDTH-1:0] fill_word(input int s, input int a);
        logic [31:0] mix;
        mix = 32'(a) * 32'h9e37_79b9 ^ (32'(s) << 28) ^ 32'h0f1e_2d3c;
        return DATA_WIDTH'(mix);
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic queue_random_words(input int n);
        repeat (n) wq.push_back(DATA_WIDTH'(next_random()));
    endtask

    // called and left at 2 ns after a rising edge
    task automatic run_cmd(input bit write, input int slave, input int addr, input int len);
        int rd_cnt;
        int wr_cnt;
        int a;
        bit got_done;
        rd_cnt    = 0;
        wr_cnt    = 0;
        got_done  = 1'b0;
        cmd_start = 1'b1;
        cmd_write = write;
        cmd_slave = ID_W'(slave);
        cmd_addr  = ADDR_W'(addr);
        cmd_len   = 5'(len);
        @(posedge clk);
        #2;
        cmd_start = 1'b0;
        check_value("busy", 64'(1), 64'(busy));
        while (!got_done) begin
            if (wr_req) begin
                a = (addr + wr_cnt) % ADDR_DEPTH;
                if (wq.size() > 0)
                    wr_data = wq.pop_front();
                else
                    wr_data = '0;  // request past the queued words
                model[ID_W'(slave)][ADDR_W'(a)] = wr_data;
                wr_cnt++;
            end
            if (rd_valid) begin
                a = (addr + rd_cnt) % ADDR_DEPTH;
                check_value($sformatf("rd_data (slave %0d addr %0h)", slave, a),
                            64'(model[ID_W'(slave)][ADDR_W'(a)]), 64'(rd_data));
                rd_cnt++;
            end
            if (done) begin
                got_done = 1'b1;
            end else begin
                @(posedge clk);
                #2;
            end
        end
        check_value("wr_req count", 64'(write ? len : 0), 64'(wr_cnt));
        check_value("rd_valid count", 64'(write ? 0 : len), 64'(rd_cnt));
        check_value("busy at done", 64'(0), 64'(busy));
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        @(posedge clk);
        #2;
        check_value("busy", 64'(0), 64'(busy));
        check_value("done", 64'(0), 64'(done));
        check_value("wr_req", 64'(0), 64'(wr_req));
        check_value("rd_valid", 64'(0), 64'(rd_valid));
        report_test("reset state", err0);
    endtask

    task automatic fill_memories();
        int err0;
        err0 = errors;
        for (int s = 0; s < SLAVES; s++) begin
            for (int base = 0; base < ADDR_DEPTH; base += 16) begin
                for (int k = 0; k < 16; k++)
                    wq.push_back(fill_word(s, base + k));
                run_cmd(1'b1, s, base, 16);
            end
        end
        report_test("memory fill", err0);
    endtask

    task automatic test_single();
        int err0;
        int a;
        err0 = errors;
        for (int s = 0; s < SLAVES; s++) begin
            a = random_below(ADDR_DEPTH);
            queue_random_words(1);
            run_cmd(1'b1, s, a, 1);
            run_cmd(1'b0, s, a, 1);
        end
        report_test("single transfer", err0);
    endtask

    task automatic test_burst_wrap();
        int err0;
        int a;
        err0 = errors;
        a = ADDR_DEPTH - 5;  // 16 words run past the top
        queue_random_words(16);
        run_cmd(1'b1, SLAVES - 1, a, 16);
        run_cmd(1'b0, SLAVES - 1, a, 16);
        report_test("burst with wrap", err0);
    endtask

    task automatic test_isolation();
        int err0;
        int a;
        err0 = errors;
        a = random_below(ADDR_DEPTH);
        queue_random_words(1);
        run_cmd(1'b1, 0, a, 1);
        for (int s = 0; s < SLAVES; s++)
            run_cmd(1'b0, s, a, 1);  // other slaves keep their old word
        report_test("slave isolation", err0);
    endtask

    task automatic test_random_mix();
        int err0;
        int w;
        int s;
        int a;
        int len;
        err0 = errors;
        for (int i = 0; i < RANDOM_CMDS; i++) begin
            w   = random_below(2);
            s   = random_below(SLAVES);
            a   = random_below(ADDR_DEPTH);
            len = 1 + random_below(16);
            if (w == 1)
                queue_random_words(len);
            run_cmd(w == 1, s, a, len);
        end
        report_test("random mix", err0);
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        cmd_slave = '0;
        cmd_addr  = '0;
        cmd_len   = 5'd1;
        wr_data   = '0;
        lcg_state = 32'd32;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        resetn = 1'b1;

        test_reset();
        fill_memories();
        test_single();
        test_burst_wrap();
        test_isolation();
        test_random_mix();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: serial_bus_top.f
serial_bus_pkg.sv
serial_link_if.sv
serial_master.sv
serial_fabric.sv
serial_slave.sv
serial_bus_top.sv
tb_serial_bus.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_serial_bus
RTL_TOP   = serial_bus_top
FILELIST  = serial_bus_top.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
